// ==== Makefile ====
# Verilator build and run for the packet merger testbench

TOP  := tb_arb_mux
SRCS := $(filter-out +%,$(shell cat files.f))

.PHONY: run clean

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

obj_dir/V$(TOP): files.f arb_cfg.svh $(SRCS)
	verilator --binary --assert --timescale 1ns/100ps --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir

// ==== arb_cfg.svh ====
/*
 * Build-time sizes for the three-channel packet merger
 * Rotation counter width, data word width, buffer depth
 */

`ifndef ARB_CFG_SVH
`define ARB_CFG_SVH

// ##########################################################
// Arbiter rotation
// ##########################################################
`define ARB_CW 4            // Token moves every 2**ARB_CW cycles

// ##########################################################
// Datapath and buffering
// ##########################################################
`define ARB_DW 16           // Data word width
`define ARB_DEPTH_LOG2 2    // 4 entries per channel buffer

`endif

// ==== arb_fifo.sv ====
/*
 * Per-channel buffer FIFO
 * Circular store with extra-bit pointers, full and empty flags
 * Combinational head word, push and pop protocol assertions
 */

`timescale 1ns/100ps
`default_nettype none

`include "arb_cfg.svh"

module arb_fifo (
   input  wire                 clk,
   input  wire                 nreset,
   input  wire                 wr,        // Push strobe from producer
   input  wire  [`ARB_DW-1:0]  wr_data,
   output logic                full,
   input  wire                 rd,        // Pop strobe from merge stage
   output logic [`ARB_DW-1:0]  rd_data,   // Head word, valid when not empty
   output logic                empty
);

   localparam int AW    = `ARB_DEPTH_LOG2;   // Address width
   localparam int DEPTH = 1 << AW;           // Entries

   // ##########################################################
   // Storage and pointers
   // ##########################################################
   logic [`ARB_DW-1:0] mem [0:DEPTH-1];      // Word store
   logic [AW:0]        wr_ptr;               // MSB is the wrap bit
   logic [AW:0]        rd_ptr;
   logic               push;                 // Qualified write
   logic               pull;                 // Qualified read

   assign push = wr & ~full;
   assign pull = rd & ~empty;

   // Same address, wrap bits differ -> buffer holds DEPTH words
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                  (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   assign empty = (wr_ptr == rd_ptr);

   // Write pointer
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
      end else if (push) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   // Read pointer
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rd_ptr <= '0;
      end else if (pull) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Store has no reset, content only matters between pointers
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr[AW-1:0]] <= wr_data;
      end
   end

   // Head word straight from the store
   assign rd_data = mem[rd_ptr[AW-1:0]];

   // ##########################################################
   // Protocol checks
   // ##########################################################
   // Producer must hold off while the buffer is full
   a_no_write_full: assert property (
      @(posedge clk) disable iff (!nreset)
      !(wr && full)
   ) else $error("arb_fifo: write while full");

   // Merge stage pops only a buffer that holds a word
   a_no_read_empty: assert property (
      @(posedge clk) disable iff (!nreset)
      !(rd && empty)
   ) else $error("arb_fifo: read while empty");

endmodule

`default_nettype wire

// ==== arb_merge.sv ====
/*
 * Merge stage, the consumer of the three buffers
 * Pop generation under wait, head word select, registered output
 */

`timescale 1ns/100ps
`default_nettype none

`include "arb_cfg.svh"

module arb_merge (
   input  wire                  clk,
   input  wire                  nreset,
   input  wire  [2:0]           grants,      // One-hot from arbiter
   input  wire  [2:0]           empty,       // Buffer empty flags
   input  wire  [`ARB_DW-1:0]   rd_data0,    // Head words
   input  wire  [`ARB_DW-1:0]   rd_data1,
   input  wire  [`ARB_DW-1:0]   rd_data2,
   output logic [2:0]           pop,         // One-hot or zero
   output logic                 out_access,
   output logic [`ARB_DW-1:0]   out_data,
   output arb_pkg::src_t        out_src,
   input  wire                  out_wait     // Level, holds the output
);

   logic                stall;              // Output word pending under wait
   logic [`ARB_DW-1:0]  head;               // Granted head word
   arb_pkg::src_t       head_src;           // Granted channel number

   // ##########################################################
   // Pop control
   // ##########################################################
   // Output register busy only while a word sits there and wait is high
   assign stall = out_access & out_wait;
   assign pop   = grants & ~empty & {3{~stall}};

   // Head word mux, grant is one-hot
   always_comb begin
      case (grants)
         3'b010: begin
            head     = rd_data1;
            head_src = 2'd1;
         end
         3'b100: begin
            head     = rd_data2;
            head_src = 2'd2;
         end
         default: begin
            head     = rd_data0;
            head_src = 2'd0;
         end
      endcase
   end

   // ##########################################################
   // Output stage
   // ##########################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         out_access <= 1'b0;
      end else if (!stall) begin
         out_access <= |pop;               // Drops when nothing was popped
      end
   end

   // Payload, loaded only on a pop
   always_ff @(posedge clk) begin
      if (|pop) begin
         out_data <= head;
         out_src  <= head_src;
      end
   end

   // Word under wait must not change or vanish
   a_hold_on_wait: assert property (
      @(posedge clk) disable iff (!nreset)
      (out_access && out_wait) |=>
         (out_access && $stable(out_data) && $stable(out_src))
   ) else $error("arb_merge: output changed during wait");

endmodule

`default_nettype wire

// ==== arb_mux_top.sv ====
/*
 * Three-channel packet merger top level
 * Three buffer FIFOs, round-robin arbiter, merge stage
 */

`timescale 1ns/100ps
`default_nettype none

`include "arb_cfg.svh"

module arb_mux_top (
   input  wire                  clk,
   input  wire                  nreset,
   input  wire                  in0_write,   // Channel 0 producer
   input  wire  [`ARB_DW-1:0]   in0_data,
   output logic                 in0_full,
   input  wire                  in1_write,   // Channel 1 producer
   input  wire  [`ARB_DW-1:0]   in1_data,
   output logic                 in1_full,
   input  wire                  in2_write,   // Channel 2 producer
   input  wire  [`ARB_DW-1:0]   in2_data,
   output logic                 in2_full,
   output logic                 out_access,  // Merged output
   output logic [`ARB_DW-1:0]   out_data,
   output arb_pkg::src_t        out_src,
   input  wire                  out_wait
);

   wire [2:0]         empty;                // Buffer empty flags
   wire [2:0]         requests;             // Not-empty, to arbiter
   wire [2:0]         grants;
   wire [2:0]         pop;
   wire [`ARB_DW-1:0] rd_data0;
   wire [`ARB_DW-1:0] rd_data1;
   wire [`ARB_DW-1:0] rd_data2;

   assign requests = ~empty;

   // Channel buffers
   arb_fifo fifo0_i (
      .clk(clk), .nreset(nreset),
      .wr(in0_write), .wr_data(in0_data), .full(in0_full),
      .rd(pop[0]), .rd_data(rd_data0), .empty(empty[0])
   );

   arb_fifo fifo1_i (
      .clk(clk), .nreset(nreset),
      .wr(in1_write), .wr_data(in1_data), .full(in1_full),
      .rd(pop[1]), .rd_data(rd_data1), .empty(empty[1])
   );

   arb_fifo fifo2_i (
      .clk(clk), .nreset(nreset),
      .wr(in2_write), .wr_data(in2_data), .full(in2_full),
      .rd(pop[2]), .rd_data(rd_data2), .empty(empty[2])
   );

   arb_rr3 #(.CW(`ARB_CW)) arb_i (         // Token steps every 16 cycles
      .clk(clk), .nreset(nreset), .requests(requests), .grants(grants)
   );

   arb_merge merge_i (
      .clk(clk), .nreset(nreset), .grants(grants), .empty(empty),
      .rd_data0(rd_data0), .rd_data1(rd_data1), .rd_data2(rd_data2),
      .pop(pop), .out_access(out_access), .out_data(out_data),
      .out_src(out_src), .out_wait(out_wait)
   );

endmodule

`default_nettype wire

// ==== arb_pkg.sv ====
/*
 * Shared types for the packet merger
 * Priority token state, output source number
 */

`default_nettype none

package arb_pkg;

   // ##########################################################
   // Arbiter token
   // ##########################################################
   // Each value names the channel that is favoured
   typedef enum logic [1:0] {
      TOK_R0 = 2'b00,   // Favour channel 0
      TOK_R1 = 2'b01,   // Favour channel 1
      TOK_R2 = 2'b10    // Favour channel 2, reset value
   } token_t;

   // ##########################################################
   // Merged output
   // ##########################################################
   // Channel number carried with each output word
   typedef logic [1:0] src_t;

endpackage

`default_nettype wire

// ==== arb_rr3.sv ====
/*
 * Three-port clocked round-robin arbiter
 * Free-running rotation counter and priority token FSM
 * Combinational one-hot grant, grant checks
 */

`timescale 1ns/100ps
`default_nettype none

`include "arb_cfg.svh"

module arb_rr3 #(
   parameter int CW = `ARB_CW                // Rotation counter width
) (
   input  wire        clk,
   input  wire        nreset,
   input  wire  [2:0] requests,             // Not-empty flags of the buffers
   output logic [2:0] grants                // Always exactly one-hot
);

   logic [CW-1:0]   counter;                // Free-running rotation counter
   logic            wrap;                   // Counter at all ones
   arb_pkg::token_t token;                  // Favoured channel

   // ##########################################################
   // Rotation counter
   // ##########################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         counter <= '0;
      end else begin
         counter <= counter + 1'b1;        // Wraps naturally
      end
   end

   assign wrap = &counter;

   // ##########################################################
   // Token FSM
   // ##########################################################
   // Stepped on clk, enabled on the wrap cycle
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         token <= arb_pkg::TOK_R2;
      end else if (wrap) begin
         case (token)
            arb_pkg::TOK_R2: token <= arb_pkg::TOK_R0;
            arb_pkg::TOK_R0: token <= arb_pkg::TOK_R1;
            default:         token <= arb_pkg::TOK_R2;   // R1 and unused code
         endcase
      end
   end

   // ##########################################################
   // Grant selection
   // ##########################################################
   // Favoured channel first, then fixed fallback order
   // No request at all -> favoured channel still granted
   always_comb begin
      case (token)
         arb_pkg::TOK_R2: begin
            if (requests[2])      grants = 3'b100;
            else if (requests[0]) grants = 3'b001;
            else if (requests[1]) grants = 3'b010;
            else                  grants = 3'b100;
         end
         arb_pkg::TOK_R1: begin
            if (requests[1])      grants = 3'b010;
            else if (requests[2]) grants = 3'b100;
            else if (requests[0]) grants = 3'b001;
            else                  grants = 3'b010;
         end
         default: begin                     // TOK_R0
            if (requests[0])      grants = 3'b001;
            else if (requests[1]) grants = 3'b010;
            else if (requests[2]) grants = 3'b100;
            else                  grants = 3'b001;
         end
      endcase
   end

   // ##########################################################
   // Checks
   // ##########################################################
   a_grant_onehot: assert property (
      @(posedge clk) disable iff (!nreset)
      $onehot(grants)
   ) else $error("arb_rr3: grant not one-hot");

   // Any pending buffer means the grant lands on a requester
   a_grant_requested: assert property (
      @(posedge clk) disable iff (!nreset)
      (|requests) |-> (|(grants & requests))
   ) else $error("arb_rr3: grant to idle channel");

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
arb_pkg.sv
arb_fifo.sv
arb_rr3.sv
arb_merge.sv
arb_mux_top.sv
tb_clock.sv
tb_arb_mux.sv

// ==== tb_arb_mux.sv ====
/*
 * Testbench for the three-channel packet merger
 * Producer and wait stimulus, reference model, concurrent checks
 */

`timescale 1ns/100ps
`default_nettype none

`include "arb_cfg.svh"

module tb_arb_mux;

   localparam int          NUM_WORDS  = 300;       // Random phase word count
   localparam int          WAIT_LIMIT = 200;       // Cycles per wait loop
   localparam int          RUN_LIMIT  = 5000;      // Cycles for the random phase
   localparam logic [31:0] LFSR_SEED  = 32'h496f061f;

   wire                clk;
   wire                nreset;
   logic [2:0]         in_write;                   // Producer strobes
   logic [`ARB_DW-1:0] in_data [0:2];
   wire  [2:0]         in_full;
   wire                out_access;
   wire  [`ARB_DW-1:0] out_data;
   arb_pkg::src_t      out_src;
   logic               out_wait;
   logic               probe;                      // Marks the single-word latency writes
   logic [`ARB_DW-1:0] probe_word;
   arb_pkg::src_t      probe_src;
   logic [31:0]        lfsr;
   logic [31:0]        bits;
   int                 written;
   int                 cycles;

   tb_clock tb_clock_i (.clk(clk), .nreset(nreset));

   arb_mux_top dut_i (
      .clk(clk), .nreset(nreset),
      .in0_write(in_write[0]), .in0_data(in_data[0]), .in0_full(in_full[0]),
      .in1_write(in_write[1]), .in1_data(in_data[1]), .in1_full(in_full[1]),
      .in2_write(in_write[2]), .in2_data(in_data[2]), .in2_full(in_full[2]),
      .out_access(out_access), .out_data(out_data), .out_src(out_src),
      .out_wait(out_wait)
   );

   // ##########################################################
   // Reference model
   // ##########################################################
   logic [`ARB_DW-1:0]            q0 [$];             // Words outstanding per source
   logic [`ARB_DW-1:0]            q1 [$];
   logic [`ARB_DW-1:0]            q2 [$];
   logic [2:0][2:0]               fill;               // Words held in each buffer
   logic [2:0][2:0]               fill_n;
   logic [`ARB_CW-1:0]            m_cnt;              // Rotation counter copy
   arb_pkg::token_t               m_tok;
   logic [3:0][`ARB_DW-1:0]       head_word;          // Expected word per source
   logic [3:0]                    has_word;
   logic                          stall;
   logic                          pop_now;
   arb_pkg::src_t                 pick;
   logic                          pick_due;           // Pop happened last edge
   logic                          prio_due;           // ... with all three buffers busy
   logic                          hold_due;           // Output was stalled last edge
   logic                          idle_due;
   logic                          lat1;
   logic                          lat2;
   arb_pkg::src_t                 pick_src;
   arb_pkg::src_t                 prio_tok;
   arb_pkg::src_t                 held_src;
   logic [`ARB_DW-1:0]            held_data;
   logic [`ARB_DW-1:0]            exp_xfer_data;
   logic [2:0]                    exp_full;
   logic                          xfer;

   assign exp_full      = {fill[2] == 3'd4, fill[1] == 3'd4, fill[0] == 3'd4};
   assign exp_xfer_data = head_word[out_src];
   assign xfer          = out_access & ~out_wait;   // Word leaves the merger

   // Grant rule, favoured channel first then fixed fallback order
   function automatic arb_pkg::src_t first_ready(input arb_pkg::token_t tok,
                                                 input logic [2:0] nz);
      logic [5:0] ord;                   // Channel numbers, best first
      case (tok)
         arb_pkg::TOK_R2: ord = {2'd2, 2'd0, 2'd1};
         arb_pkg::TOK_R1: ord = {2'd1, 2'd2, 2'd0};
         default:         ord = {2'd0, 2'd1, 2'd2};
      endcase
      if (nz[ord[5:4]]) return ord[5:4];
      else if (nz[ord[3:2]]) return ord[3:2];
      else if (nz[ord[1:0]]) return ord[1:0];
      else return ord[5:4];              // No request, favoured channel
   endfunction

   always @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         q0.delete();
         q1.delete();
         q2.delete();
         fill      <= '0;
         m_cnt     <= '0;
         m_tok     <= arb_pkg::TOK_R2;
         head_word <= '0;
         has_word  <= 4'b0000;
         pick_due  <= 1'b0;
         prio_due  <= 1'b0;
         hold_due  <= 1'b0;
         idle_due  <= 1'b0;
         lat1      <= 1'b0;
         lat2      <= 1'b0;
      end else begin
         fill_n  = fill;
         stall   = out_access & out_wait;
         pop_now = !stall && (fill[0] != 3'd0 || fill[1] != 3'd0 || fill[2] != 3'd0);
         pick    = first_ready(m_tok, {fill[2] != 3'd0, fill[1] != 3'd0, fill[0] != 3'd0});
         if (pop_now) fill_n[pick] = fill_n[pick] - 3'd1;
         if (xfer) begin                 // Retire before new words land
            case (out_src)
               2'd0: if (q0.size() != 0) void'(q0.pop_front());
               2'd1: if (q1.size() != 0) void'(q1.pop_front());
               2'd2: if (q2.size() != 0) void'(q2.pop_front());
               default: ;
            endcase
         end
         if (in_write[0]) q0.push_back(in_data[0]);
         if (in_write[1]) q1.push_back(in_data[1]);
         if (in_write[2]) q2.push_back(in_data[2]);
         for (int i = 0; i < 3; i++) begin
            if (in_write[i]) fill_n[i] = fill_n[i] + 3'd1;
         end
         fill         <= fill_n;
         has_word     <= {1'b0, q2.size() != 0, q1.size() != 0, q0.size() != 0};
         head_word[0] <= (q0.size() != 0) ? q0[0] : '0;
         head_word[1] <= (q1.size() != 0) ? q1[0] : '0;
         head_word[2] <= (q2.size() != 0) ? q2[0] : '0;
         pick_due     <= pop_now;
         pick_src     <= pick;
         prio_due     <= pop_now && fill[0] != 3'd0 && fill[1] != 3'd0 && fill[2] != 3'd0;
         prio_tok     <= first_ready(m_tok, 3'b111);   // Favoured channel
         hold_due     <= stall;
         held_data    <= out_data;
         held_src     <= out_src;
         idle_due     <= !pop_now && !stall;
         lat2         <= lat1;           // Probe word due two edges on
         lat1         <= probe;
         m_cnt        <= m_cnt + 1'b1;
         if (&m_cnt) begin               // Token steps R2 -> R0 -> R1 -> R2
            case (m_tok)
               arb_pkg::TOK_R2: m_tok <= arb_pkg::TOK_R0;
               arb_pkg::TOK_R0: m_tok <= arb_pkg::TOK_R1;
               default:         m_tok <= arb_pkg::TOK_R2;
            endcase
         end
      end
   end

   // ##########################################################
   // Failure reporting
   // ##########################################################
   task automatic halt_sim();
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic show_mismatch(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      $display("error %0t %s expected %h got %h", $time, name, exp, act);
      halt_sim();
   endtask

   task automatic abort_run(input string why);
      $display("%s at %0t", why, $time);
      halt_sim();
   endtask

   // ##########################################################
   // Checks
   // ##########################################################
   a_reset_quiet: assert property (@(posedge clk)
      !nreset |-> !out_access && in_full == 3'b000
   ) else abort_run("outputs active while reset is held");

   a_full_flag: assert property (@(posedge clk) disable iff (!nreset)
      in_full == exp_full
   ) else show_mismatch("in_full", 32'($sampled(exp_full)), 32'($sampled(in_full)));

   a_xfer_known: assert property (@(posedge clk) disable iff (!nreset)
      xfer |-> has_word[out_src]
   ) else abort_run("word transferred on a source with nothing outstanding");

   a_xfer_data: assert property (@(posedge clk) disable iff (!nreset)
      xfer |-> out_data == exp_xfer_data
   ) else show_mismatch("out_data", 32'($sampled(exp_xfer_data)), 32'($sampled(out_data)));

   // Loaded after a pop, kept while stalled
   a_busy: assert property (@(posedge clk) disable iff (!nreset)
      (pick_due || hold_due) |-> out_access
   ) else show_mismatch("out_access", 32'd1, 32'($sampled(out_access)));

   a_idle: assert property (@(posedge clk) disable iff (!nreset)
      idle_due |-> !out_access
   ) else show_mismatch("out_access", 32'd0, 32'($sampled(out_access)));

   a_pop_source: assert property (@(posedge clk) disable iff (!nreset)
      pick_due |-> out_src == pick_src
   ) else show_mismatch("out_src", 32'($sampled(pick_src)), 32'($sampled(out_src)));

   a_token_priority: assert property (@(posedge clk) disable iff (!nreset)
      prio_due |-> out_src == prio_tok
   ) else show_mismatch("out_src", 32'($sampled(prio_tok)), 32'($sampled(out_src)));

   a_hold_data: assert property (@(posedge clk) disable iff (!nreset)
      hold_due |-> out_data == held_data
   ) else show_mismatch("out_data", 32'($sampled(held_data)), 32'($sampled(out_data)));

   a_hold_source: assert property (@(posedge clk) disable iff (!nreset)
      hold_due |-> out_src == held_src
   ) else show_mismatch("out_src", 32'($sampled(held_src)), 32'($sampled(out_src)));

   a_latency_data: assert property (@(posedge clk) disable iff (!nreset)
      lat2 |-> out_access && out_data == probe_word
   ) else show_mismatch("out_data", 32'($sampled(probe_word)), 32'($sampled(out_data)));

   a_latency_source: assert property (@(posedge clk) disable iff (!nreset)
      lat2 |-> out_src == probe_src
   ) else show_mismatch("out_src", 32'($sampled(probe_src)), 32'($sampled(out_src)));

   // ##########################################################
   // Stimulus
   // ##########################################################
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32,22,2,1
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int b = 0; b < n; b++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic step_cycle();
      @(posedge clk);
      #10;                               // Inputs change away from the edge
   endtask

   task automatic drain_all();
      int n;
      n = 0;
      while (q0.size() + q1.size() + q2.size() != 0 || out_access) begin
         if (n == WAIT_LIMIT) abort_run("timeout waiting for the merger to drain");
         step_cycle();
         n++;
      end
   endtask

   task automatic await_loaded();
      int n;
      n = 0;
      while (!out_access) begin
         if (n == WAIT_LIMIT) abort_run("timeout waiting for out_access");
         step_cycle();
         n++;
      end
   endtask

   task automatic poll_full();
      int n;
      n = 0;
      while (!in_full[0]) begin
         if (n == WAIT_LIMIT) abort_run("timeout waiting for channel 0 full");
         step_cycle();
         n++;
      end
   endtask

   initial begin
      in_write   = 3'b000;
      in_data[0] = '0;
      in_data[1] = '0;
      in_data[2] = '0;
      out_wait   = 1'b0;
      probe      = 1'b0;
      probe_word = '0;
      probe_src  = 2'd0;
      lfsr       = LFSR_SEED;
      written    = 0;
      cycles     = 0;
      while (!nreset) begin
         if (cycles == WAIT_LIMIT) abort_run("reset never released");
         @(posedge clk);
         cycles++;
      end
      step_cycle();

      // Single words on an idle merger
      for (int ch = 0; ch < 3; ch++) begin
         take_bits(16, bits);
         probe_word   = bits[`ARB_DW-1:0];
         probe_src    = 2'(ch);
         in_data[ch]  = probe_word;
         in_write[ch] = 1'b1;
         probe        = 1'b1;
         step_cycle();
         in_write     = 3'b000;
         probe        = 1'b0;
         drain_all();
      end

      // Park a word under wait, then fill channel 0
      out_wait    = 1'b1;
      take_bits(16, bits);
      in_data[1]  = bits[`ARB_DW-1:0];
      in_write[1] = 1'b1;
      step_cycle();
      in_write    = 3'b000;
      await_loaded();
      for (int n = 0; n < 4; n++) begin
         take_bits(16, bits);
         in_data[0]  = bits[`ARB_DW-1:0];
         in_write[0] = 1'b1;
         step_cycle();
      end
      in_write = 3'b000;
      poll_full();
      repeat (8) step_cycle();           // Output held, buffer stays full
      out_wait = 1'b0;
      drain_all();

      // Random producers and random wait
      cycles = 0;
      while (written < NUM_WORDS) begin
         if (cycles == RUN_LIMIT) abort_run("random phase ran out of cycles");
         for (int ch = 0; ch < 3; ch++) begin
            take_bits(2, bits);
            in_write[ch] = (&bits[1:0]) && !in_full[ch];   // About one in four
            take_bits(16, bits);
            in_data[ch] = bits[`ARB_DW-1:0];
            if (in_write[ch]) written++;
         end
         take_bits(2, bits);
         out_wait = &bits[1:0];
         step_cycle();
         cycles++;
      end
      in_write = 3'b000;
      out_wait = 1'b0;
      drain_all();

      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
/*
 * Testbench clock and reset generator
 * 100 ns clock, reset low for the first 4 cycles
 */

`timescale 1ns/100ps
`default_nettype none

module tb_clock (
   output logic clk,
   output logic nreset
);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;            // 100 ns period
   end

   // Release a little after the 4th rising edge
   initial begin
      nreset = 1'b0;
      repeat (4) @(posedge clk);
      #10 nreset = 1'b1;
   end

endmodule

`default_nettype wire
